/* flist.f */
hw/hyper_pkg.sv
hw/hyperbus_pkg.sv
hw/hyper_axil_port.sv
hw/hyper_arbiter.sv
hw/hyper_phy.sv
hw/hyper_top.sv
dv/hyper_ram_model.sv
dv/tb_hyper_top.sv

/* Bender.yml */
package:
  name: hyper_top

sources:
  - hw/hyper_pkg.sv
  - hw/hyperbus_pkg.sv
  - hw/hyper_axil_port.sv
  - hw/hyper_arbiter.sv
  - hw/hyper_phy.sv
  - hw/hyper_top.sv
  - target: test
    files:
      - dv/hyper_ram_model.sv
      - dv/tb_hyper_top.sv

/* dv/tb_hyper_top.sv */
// testbench for the HyperBus controller top level
// two AXI4-Lite hosts driven on the falling edge, LFSR data and strobes
// shadow memory, concurrent checks, watchdog and final report
`timescale 1ns/1ns

module tb_hyper_top;

  localparam int LATENCY_CK = 6;
  localparam int MEM_AW     = 12;
  // accesses issued by the whole sequence
  localparam int N_ACC      = 30;
  localparam int TIMEOUT_NS = (N_ACC * 40 + 20) * 4;

  logic clk_i = 1'b0;
  logic reset_i;

  logic             awvalid [2];
  logic             awready [2];
  hyper_pkg::addr_t awaddr  [2];
  logic             wvalid  [2];
  logic             wready  [2];
  hyper_pkg::data_t wdata   [2];
  hyper_pkg::strb_t wstrb   [2];
  logic             bvalid  [2];
  logic             bready  [2];
  hyper_pkg::resp_t bresp   [2];
  logic             arvalid [2];
  logic             arready [2];
  hyper_pkg::addr_t araddr  [2];
  logic             rvalid  [2];
  logic             rready  [2];
  hyper_pkg::data_t rdata   [2];
  hyper_pkg::resp_t rresp   [2];

  logic       cs_n;
  logic       ck;
  logic       ck_n;
  logic       bus_reset_n;
  logic       rwds_out;
  logic       rwds_in;
  logic       rwds_oe;
  logic [7:0] dq_out;
  logic [7:0] dq_in;
  logic       dq_oe;

  logic [7:0]       shadow [1 << MEM_AW];
  hyper_pkg::resp_t exp_bresp [2];
  hyper_pkg::resp_t exp_rresp [2];
  hyper_pkg::data_t exp_rdata [2];
  logic [47:0]      exp_ca;
  logic [47:0]      ca_cap;
  int               ca_cnt;
  logic             ca_check_en;
  logic             oor_active;
  logic             hold_phase;
  int               p1_while_blocked;
  logic [1:0]       prev_done;
  logic             prev_pend;
  logic [15:0]      lfsr_q;
  int               errors;

  always #2 clk_i = !clk_i;

  hyper_top #(
    .LATENCY_CK(LATENCY_CK),
    .MEM_ADDR_WIDTH(MEM_AW)
  ) UUT (
    .clk_i(clk_i), .reset_i(reset_i),
    .p0_awvalid_i(awvalid[0]), .p0_awready_o(awready[0]), .p0_awaddr_i(awaddr[0]),
    .p0_wvalid_i(wvalid[0]), .p0_wready_o(wready[0]),
    .p0_wdata_i(wdata[0]), .p0_wstrb_i(wstrb[0]),
    .p0_bvalid_o(bvalid[0]), .p0_bready_i(bready[0]), .p0_bresp_o(bresp[0]),
    .p0_arvalid_i(arvalid[0]), .p0_arready_o(arready[0]), .p0_araddr_i(araddr[0]),
    .p0_rvalid_o(rvalid[0]), .p0_rready_i(rready[0]),
    .p0_rdata_o(rdata[0]), .p0_rresp_o(rresp[0]),
    .p1_awvalid_i(awvalid[1]), .p1_awready_o(awready[1]), .p1_awaddr_i(awaddr[1]),
    .p1_wvalid_i(wvalid[1]), .p1_wready_o(wready[1]),
    .p1_wdata_i(wdata[1]), .p1_wstrb_i(wstrb[1]),
    .p1_bvalid_o(bvalid[1]), .p1_bready_i(bready[1]), .p1_bresp_o(bresp[1]),
    .p1_arvalid_i(arvalid[1]), .p1_arready_o(arready[1]), .p1_araddr_i(araddr[1]),
    .p1_rvalid_o(rvalid[1]), .p1_rready_i(rready[1]),
    .p1_rdata_o(rdata[1]), .p1_rresp_o(rresp[1]),
    .hyper_cs_no_o(cs_n), .hyper_ck_o(ck), .hyper_ck_no_o(ck_n),
    .hyper_reset_no_o(bus_reset_n),
    .hyper_rwds_o(rwds_out), .hyper_rwds_i(rwds_in), .hyper_rwds_oe_o(rwds_oe),
    .hyper_dq_o(dq_out), .hyper_dq_i(dq_in), .hyper_dq_oe_o(dq_oe)
  );

  hyper_ram_model #(
    .LATENCY_CK(LATENCY_CK),
    .MEM_ADDR_WIDTH(MEM_AW)
  ) u_ram (
    .cs_n_i(cs_n), .ck_i(ck), .rwds_i(rwds_out), .rwds_oe_i(rwds_oe),
    .dq_i(dq_out), .dq_oe_i(dq_oe), .rwds_o(rwds_in), .dq_o(dq_in)
  );

  task automatic note_mismatch(input string what);
    errors++;
    $display("Mismatch at %0t ns: %s", $time, what);
  endtask

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic        fb;
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [47:0] ca_word(input logic rd, input hyper_pkg::addr_t a);
    logic [31:0] hw;
    hw = {1'b0, a[31:1]};
    return {rd, 1'b0, 1'b1, hw[31:3], 13'b0, hw[2:0]};
  endfunction

  task automatic store_word(input int p, input hyper_pkg::addr_t a, input hyper_pkg::data_t d,
                            input hyper_pkg::strb_t s, input int hold);
    @(negedge clk_i);
    if (a < (32'd1 << MEM_AW)) begin
      exp_bresp[p] = hyper_pkg::RESP_OKAY;
      for (int b = 0; b < 4; b++) begin
        if (s[b]) shadow[{a[MEM_AW-1:2], 2'b00} + b] = d[b*8 +: 8];
      end
    end else begin
      exp_bresp[p] = hyper_pkg::RESP_SLVERR;
    end
    exp_ca     = ca_word(1'b0, {a[31:2], 2'b00});
    awvalid[p] = 1'b1;
    awaddr[p]  = a;
    wvalid[p]  = 1'b1;
    wdata[p]   = d;
    wstrb[p]   = s;
    forever begin
      #1;
      if (awready[p] && wready[p]) break;
      @(negedge clk_i);
    end
    @(negedge clk_i);
    awvalid[p] = 1'b0;
    wvalid[p]  = 1'b0;
    while (!bvalid[p]) @(negedge clk_i);
    repeat (hold) @(negedge clk_i);
    bready[p] = 1'b1;
    @(negedge clk_i);
    bready[p] = 1'b0;
  endtask

  task automatic fetch_word(input int p, input hyper_pkg::addr_t a, input int hold);
    @(negedge clk_i);
    if (a < (32'd1 << MEM_AW)) begin
      exp_rresp[p] = hyper_pkg::RESP_OKAY;
      for (int b = 0; b < 4; b++) begin
        exp_rdata[p][b*8 +: 8] = shadow[{a[MEM_AW-1:2], 2'b00} + b];
      end
    end else begin
      exp_rresp[p] = hyper_pkg::RESP_SLVERR;
      exp_rdata[p] = '0;
    end
    exp_ca      = ca_word(1'b1, {a[31:2], 2'b00});
    arvalid[p]  = 1'b1;
    araddr[p]   = a;
    forever begin
      #1;
      if (arready[p]) break;
      @(negedge clk_i);
    end
    @(negedge clk_i);
    arvalid[p] = 1'b0;
    while (!rvalid[p]) @(negedge clk_i);
    repeat (hold) @(negedge clk_i);
    rready[p] = 1'b1;
    @(negedge clk_i);
    rready[p] = 1'b0;
  endtask

  // write then read back random words in a port's own region
  task automatic write_read_loop(input int p, input hyper_pkg::addr_t base, input int n);
    logic [31:0] d;
    logic [31:0] s;
    for (int i = 0; i < n; i++) begin
      d = rand_bits(32);
      s = rand_bits(4);
      store_word(p, base + 4 * i, d, s[3:0] | 4'b0001, 0);
      fetch_word(p, base + 4 * i, 0);
    end
  endtask

  // capture the command/address bytes of every transaction
  always @(posedge clk_i) begin
    if (cs_n) begin
      ca_cnt <= 0;
    end else if (dq_oe && ca_cnt < 6) begin
      ca_cap <= {ca_cap[39:0], dq_out};
      ca_cnt <= ca_cnt + 1;
    end
  end

  always @(posedge clk_i) begin
    if (UUT.done != 2'b00) begin
      prev_done <= UUT.done;
      prev_pend <= |(UUT.req & ~UUT.done);
    end
    if (hold_phase && ((bvalid[0] && !bready[0]) || (rvalid[0] && !rready[0])) &&
        ((bvalid[1] && bready[1]) || (rvalid[1] && rready[1]))) begin
      p1_while_blocked++;
    end
  end

  a_reset_state: assert property (@(posedge clk_i) $fell(reset_i) |->
    cs_n && ck && !dq_oe && !rwds_oe && !bvalid[0] && !rvalid[0] && !bvalid[1] &&
    !rvalid[1] && !awready[0] && !arready[0] && !awready[1] && !arready[1])
    else note_mismatch("bus or port not idle after reset");
  a_bus_reset: assert property (@(posedge clk_i) $fell(reset_i) |=> bus_reset_n)
    else note_mismatch("bus reset still asserted");
  a_ck_pair: assert property (@(posedge clk_i) disable iff (reset_i) ck_n == !ck)
    else note_mismatch("bus clock pair not complementary");
  a_ca_word: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(cs_n) && ca_check_en |-> ca_cap == exp_ca)
    else note_mismatch("command/address word");
  a_oor_no_bus: assert property (@(posedge clk_i) disable iff (reset_i) oor_active |-> cs_n)
    else note_mismatch("chip select fell for an out-of-range access");
  a_alternate: assert property (@(posedge clk_i) disable iff (reset_i)
    UUT.done != 2'b00 && prev_pend |-> UUT.done != prev_done)
    else note_mismatch("completions did not alternate");

  for (genvar p = 0; p < 2; p++) begin : g_port_checks
    a_aw_w_together: assert property (@(posedge clk_i) disable iff (reset_i)
      awready[p] == wready[p])
      else note_mismatch("address and data of a write not accepted together");
    a_bresp: assert property (@(posedge clk_i) disable iff (reset_i)
      bvalid[p] && bready[p] |-> bresp[p] == exp_bresp[p])
      else note_mismatch("write response");
    a_rdata: assert property (@(posedge clk_i) disable iff (reset_i)
      rvalid[p] && rready[p] |-> rdata[p] == exp_rdata[p] && rresp[p] == exp_rresp[p])
      else note_mismatch("read data or response");
    a_b_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      bvalid[p] && !bready[p] |=> bvalid[p] && $stable(bresp[p]))
      else note_mismatch("write response changed while stalled");
    a_r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      rvalid[p] && !rready[p] |=> rvalid[p] && $stable(rdata[p]) && $stable(rresp[p]))
      else note_mismatch("read response changed while stalled");
    a_aw_range: assert property (@(posedge clk_i) disable iff (reset_i)
      awvalid[p] && awready[p] && awaddr[p] >= (32'd1 << MEM_AW) |=>
      bvalid[p] && bresp[p] == hyper_pkg::RESP_SLVERR)
      else note_mismatch("out-of-range write not rejected in one cycle");
    a_ar_range: assert property (@(posedge clk_i) disable iff (reset_i)
      arvalid[p] && arready[p] && araddr[p] >= (32'd1 << MEM_AW) |=>
      rvalid[p] && rresp[p] == hyper_pkg::RESP_SLVERR)
      else note_mismatch("out-of-range read not rejected in one cycle");
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the accesses did not complete in time");
    $display("%0d errors", errors);
    $display("Checks failed");
    $finish;
  end

  initial begin
    logic [31:0] d;
    errors           = 0;
    lfsr_q           = 16'd27;
    ca_cap           = '0;
    ca_cnt           = 0;
    exp_ca           = '0;
    ca_check_en      = 1'b0;
    oor_active       = 1'b0;
    hold_phase       = 1'b0;
    p1_while_blocked = 0;
    prev_done        = 2'b00;
    prev_pend        = 1'b0;
    for (int p = 0; p < 2; p++) begin
      awvalid[p] = 1'b0;
      awaddr[p]  = '0;
      wvalid[p]  = 1'b0;
      wdata[p]   = '0;
      wstrb[p]   = '0;
      bready[p]  = 1'b0;
      arvalid[p] = 1'b0;
      araddr[p]  = '0;
      rready[p]  = 1'b0;
      exp_bresp[p] = hyper_pkg::RESP_OKAY;
      exp_rresp[p] = hyper_pkg::RESP_OKAY;
      exp_rdata[p] = '0;
    end
    reset_i = 1'b1;
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;

    // shadow starts from the model's initial contents
    for (int i = 0; i < (1 << MEM_AW); i++) begin
      shadow[i] = u_ram.mem[i];
    end

    // single port with basic, partial strobe, range and ca checks
    ca_check_en = 1'b1;
    d = rand_bits(32);
    store_word(0, 32'h010, d, 4'hf, 0);
    fetch_word(0, 32'h010, 0);
    d = rand_bits(32);
    store_word(0, 32'h020, d, 4'hf, 0);
    d = rand_bits(32);
    store_word(0, 32'h020, d, 4'b0101, 0);
    fetch_word(0, 32'h020, 0);
    oor_active = 1'b1;
    store_word(0, 32'h1010, 32'hdead_beef, 4'hf, 0);
    fetch_word(0, 32'h1020, 0);
    oor_active = 1'b0;
    fetch_word(0, 32'h010, 0);
    ca_check_en = 1'b0;

    // both ports at once
    fork
      write_read_loop(0, 32'h100, 4);
      write_read_loop(1, 32'h800, 4);
    join

    // port 0 stalls its responses while port 1 keeps going
    hold_phase = 1'b1;
    fork
      begin
        d = rand_bits(32);
        store_word(0, 32'h200, d, 4'hf, 30);
        fetch_word(0, 32'h200, 30);
      end
      write_read_loop(1, 32'h900, 2);
    join
    hold_phase = 1'b0;
    if (p1_while_blocked == 0) begin
      errors++;
      $display("Port 1 completed nothing while port 0 held its response");
    end

    repeat (4) @(negedge clk_i);
    $display("%0d errors", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* dv/hyper_ram_model.sv */
// behavioral HyperRAM for simulation
// decodes the command/address bytes, fixed initial latency
// stores write bytes unless rwds masks them, answers reads with rwds toggles
`timescale 1ns/1ns

module hyper_ram_model #(
  parameter int LATENCY_CK     = 6,
  parameter int MEM_ADDR_WIDTH = 12
) (
  input  logic       cs_n_i,
  input  logic       ck_i,
  input  logic       rwds_i,
  input  logic       rwds_oe_i,
  input  logic [7:0] dq_i,
  input  logic       dq_oe_i,
  output logic       rwds_o,
  output logic [7:0] dq_o
);

  localparam int MEM_BYTES = 1 << MEM_ADDR_WIDTH;
  // first ck edge of the data phase
  localparam int DATA_EDGE = 6 + 2 * LATENCY_CK;

  logic [7:0]  mem [MEM_BYTES];
  logic [47:0] ca;
  logic [31:0] base;
  int          edge_cnt;

  // fill pattern mixes every address bit
  initial begin
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = i[7:0] ^ {i[3:0], i[11:8]};
    end
    ca       = '0;
    base     = '0;
    edge_cnt = 0;
    rwds_o   = 1'b0;
    dq_o     = '0;
  end

  // end of transaction
  always @(posedge cs_n_i) begin
    edge_cnt = 0;
    rwds_o   = 1'b0;
  end

  // both ck edges carry a byte
  always @(ck_i) begin
    int idx;
    if (cs_n_i === 1'b0) begin
      if (edge_cnt < 6) begin
        ca = {ca[39:0], dq_i};
      end else if (edge_cnt >= DATA_EDGE && edge_cnt < DATA_EDGE + 4) begin
        // half-word address back to a byte address
        base = {ca[43:16], ca[2:0], 1'b0};
        idx  = (base + (edge_cnt - DATA_EDGE)) & (MEM_BYTES - 1);
        if (ca[47]) begin
          dq_o   = mem[idx];
          rwds_o = !rwds_o;
        end else if (dq_oe_i && rwds_oe_i && !rwds_i) begin
          mem[idx] = dq_i;
        end
      end
      edge_cnt++;
    end
  end

endmodule

/* hw/hyper_top.sv */
// HyperBus memory controller top level
// two AXI4-Lite host ports sharing one PHY via round-robin arbiter
`timescale 1ns/1ns

module hyper_top #(
  parameter int LATENCY_CK     = 6,
  parameter int MEM_ADDR_WIDTH = 12
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                p0_awvalid_i,
  output logic                p0_awready_o,
  input  hyper_pkg::addr_t    p0_awaddr_i,
  input  logic                p0_wvalid_i,
  output logic                p0_wready_o,
  input  hyper_pkg::data_t    p0_wdata_i,
  input  hyper_pkg::strb_t    p0_wstrb_i,
  output logic                p0_bvalid_o,
  input  logic                p0_bready_i,
  output hyper_pkg::resp_t    p0_bresp_o,
  input  logic                p0_arvalid_i,
  output logic                p0_arready_o,
  input  hyper_pkg::addr_t    p0_araddr_i,
  output logic                p0_rvalid_o,
  input  logic                p0_rready_i,
  output hyper_pkg::data_t    p0_rdata_o,
  output hyper_pkg::resp_t    p0_rresp_o,
  input  logic                p1_awvalid_i,
  output logic                p1_awready_o,
  input  hyper_pkg::addr_t    p1_awaddr_i,
  input  logic                p1_wvalid_i,
  output logic                p1_wready_o,
  input  hyper_pkg::data_t    p1_wdata_i,
  input  hyper_pkg::strb_t    p1_wstrb_i,
  output logic                p1_bvalid_o,
  input  logic                p1_bready_i,
  output hyper_pkg::resp_t    p1_bresp_o,
  input  logic                p1_arvalid_i,
  output logic                p1_arready_o,
  input  hyper_pkg::addr_t    p1_araddr_i,
  output logic                p1_rvalid_o,
  input  logic                p1_rready_i,
  output hyper_pkg::data_t    p1_rdata_o,
  output hyper_pkg::resp_t    p1_rresp_o,
  output logic                hyper_cs_no_o,
  output logic                hyper_ck_o,
  output logic                hyper_ck_no_o,
  output logic                hyper_reset_no_o,
  output logic                hyper_rwds_o,
  input  logic                hyper_rwds_i,
  output logic                hyper_rwds_oe_o,
  output hyperbus_pkg::byte_t hyper_dq_o,
  input  hyperbus_pkg::byte_t hyper_dq_i,
  output logic                hyper_dq_oe_o
);

  // per-port requests into the arbiter
  logic [1:0]       req;
  logic [1:0]       we;
  logic [1:0]       done;
  hyper_pkg::addr_t addr  [1:0];
  hyper_pkg::data_t wdata [1:0];
  hyper_pkg::strb_t wstrb [1:0];

  logic             phy_req;
  logic             phy_we;
  logic             phy_done;
  hyper_pkg::addr_t phy_addr;
  hyper_pkg::data_t phy_wdata;
  hyper_pkg::strb_t phy_wstrb;
  hyper_pkg::data_t phy_rdata;

  hyper_axil_port #(
    .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
  ) u_port0 (
    .clk_i(clk_i), .reset_i(reset_i),
    .s_awvalid_i(p0_awvalid_i), .s_awready_o(p0_awready_o), .s_awaddr_i(p0_awaddr_i),
    .s_wvalid_i(p0_wvalid_i), .s_wready_o(p0_wready_o),
    .s_wdata_i(p0_wdata_i), .s_wstrb_i(p0_wstrb_i),
    .s_bvalid_o(p0_bvalid_o), .s_bready_i(p0_bready_i), .s_bresp_o(p0_bresp_o),
    .s_arvalid_i(p0_arvalid_i), .s_arready_o(p0_arready_o), .s_araddr_i(p0_araddr_i),
    .s_rvalid_o(p0_rvalid_o), .s_rready_i(p0_rready_i),
    .s_rdata_o(p0_rdata_o), .s_rresp_o(p0_rresp_o),
    .req_o(req[0]), .we_o(we[0]), .addr_o(addr[0]),
    .wdata_o(wdata[0]), .wstrb_o(wstrb[0]),
    .done_i(done[0]), .rdata_i(phy_rdata)
  );

  hyper_axil_port #(
    .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
  ) u_port1 (
    .clk_i(clk_i), .reset_i(reset_i),
    .s_awvalid_i(p1_awvalid_i), .s_awready_o(p1_awready_o), .s_awaddr_i(p1_awaddr_i),
    .s_wvalid_i(p1_wvalid_i), .s_wready_o(p1_wready_o),
    .s_wdata_i(p1_wdata_i), .s_wstrb_i(p1_wstrb_i),
    .s_bvalid_o(p1_bvalid_o), .s_bready_i(p1_bready_i), .s_bresp_o(p1_bresp_o),
    .s_arvalid_i(p1_arvalid_i), .s_arready_o(p1_arready_o), .s_araddr_i(p1_araddr_i),
    .s_rvalid_o(p1_rvalid_o), .s_rready_i(p1_rready_i),
    .s_rdata_o(p1_rdata_o), .s_rresp_o(p1_rresp_o),
    .req_o(req[1]), .we_o(we[1]), .addr_o(addr[1]),
    .wdata_o(wdata[1]), .wstrb_o(wstrb[1]),
    .done_i(done[1]), .rdata_i(phy_rdata)
  );

  hyper_arbiter u_arbiter (
    .clk_i(clk_i), .reset_i(reset_i),
    .req_i(req), .we_i(we), .addr_i(addr), .wdata_i(wdata), .wstrb_i(wstrb),
    .done_o(done),
    .phy_req_o(phy_req), .phy_we_o(phy_we), .phy_addr_o(phy_addr),
    .phy_wdata_o(phy_wdata), .phy_wstrb_o(phy_wstrb), .phy_done_i(phy_done)
  );

  hyper_phy #(
    .LATENCY_CK(LATENCY_CK)
  ) u_phy (
    .clk_i(clk_i), .reset_i(reset_i),
    .req_i(phy_req), .we_i(phy_we), .addr_i(phy_addr),
    .wdata_i(phy_wdata), .wstrb_i(phy_wstrb),
    .done_o(phy_done), .rdata_o(phy_rdata),
    .hyper_cs_no_o(hyper_cs_no_o), .hyper_ck_o(hyper_ck_o),
    .hyper_ck_no_o(hyper_ck_no_o), .hyper_reset_no_o(hyper_reset_no_o),
    .hyper_rwds_o(hyper_rwds_o), .hyper_rwds_i(hyper_rwds_i),
    .hyper_rwds_oe_o(hyper_rwds_oe_o),
    .hyper_dq_o(hyper_dq_o), .hyper_dq_i(hyper_dq_i), .hyper_dq_oe_o(hyper_dq_oe_o)
  );

endmodule

/* hw/hyper_phy.sv */
// HyperBus transaction engine for one 32-bit access
// command/address, fixed initial latency, data phase, chip select
// bus clock at half of clk_i, one DQ byte per clk_i cycle
`timescale 1ns/1ns

module hyper_phy #(
  parameter int LATENCY_CK = 6
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                req_i,
  input  logic                we_i,
  input  hyper_pkg::addr_t    addr_i,
  input  hyper_pkg::data_t    wdata_i,
  input  hyper_pkg::strb_t    wstrb_i,
  output logic                done_o,
  output hyper_pkg::data_t    rdata_o,
  output logic                hyper_cs_no_o,
  output logic                hyper_ck_o,
  output logic                hyper_ck_no_o,
  output logic                hyper_reset_no_o,
  output logic                hyper_rwds_o,
  input  logic                hyper_rwds_i,
  output logic                hyper_rwds_oe_o,
  output hyperbus_pkg::byte_t hyper_dq_o,
  input  hyperbus_pkg::byte_t hyper_dq_i,
  output logic                hyper_dq_oe_o
);

  // one ck edge per clk_i cycle
  localparam int LAT_CYCLES = 2 * LATENCY_CK;
  localparam int CNT_W      = $clog2(LAT_CYCLES + hyperbus_pkg::CA_BYTES + 1);

  localparam logic [CNT_W-1:0] CA_LAST   = CNT_W'(hyperbus_pkg::CA_BYTES - 1);
  localparam logic [CNT_W-1:0] LAT_LAST  = CNT_W'(LAT_CYCLES - 1);
  localparam logic [CNT_W-1:0] DATA_LAST = CNT_W'(hyperbus_pkg::WORD_BYTES - 1);

  typedef enum logic [2:0] {ST_IDLE, ST_CA, ST_LATENCY, ST_DATA, ST_FINISH} state_e;

  state_e            state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              cs_n_q;
  logic              ck_q;
  logic              reset_n_q;
  logic              we_q;
  hyperbus_pkg::ca_t ca_q;
  hyper_pkg::data_t  wdata_q;
  hyper_pkg::strb_t  wstrb_q;
  hyper_pkg::data_t  rdata_q;
  logic              rwds_prev_q;
  logic              rd_strobe;
  logic [1:0]        byte_idx;

  assign byte_idx  = cnt_q[1:0];
  // every rwds transition marks a new read byte
  assign rd_strobe = (hyper_rwds_i != rwds_prev_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      cs_n_q  <= 1'b1;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            state_q <= ST_CA;
            cnt_q   <= '0;
            cs_n_q  <= 1'b0;
          end
        end
        ST_CA: begin
          if (cnt_q == CA_LAST) begin
            state_q <= ST_LATENCY;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        ST_LATENCY: begin
          if (cnt_q == LAT_LAST) begin
            state_q <= ST_DATA;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        ST_DATA: begin
          // writes move a byte each cycle, reads wait for rwds
          if (we_q || rd_strobe) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == DATA_LAST) begin
              state_q <= ST_FINISH;
              cs_n_q  <= 1'b1;
            end
          end
        end
        ST_FINISH: state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_i) begin
      we_q    <= we_i;
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
      // device addresses half-words
      ca_q    <= hyperbus_pkg::build_ca(!we_i, addr_i >> 1);
    end else if (state_q == ST_CA) begin
      ca_q <= ca_q << 8;
    end
    // read strobe starts low
    if (state_q == ST_LATENCY) begin
      rwds_prev_q <= 1'b0;
    end else if (state_q == ST_DATA) begin
      rwds_prev_q <= hyper_rwds_i;
    end
    if (state_q == ST_DATA && !we_q && rd_strobe) begin
      rdata_q[byte_idx*8 +: 8] <= hyper_dq_i;
    end
  end

  // ck edges centred in each byte, idle high
  always_ff @(negedge clk_i) begin
    if (reset_i || cs_n_q) begin
      ck_q <= 1'b1;
    end else begin
      ck_q <= !ck_q;
    end
  end

  always_ff @(posedge clk_i) begin
    reset_n_q <= !reset_i;
  end

  assign hyper_cs_no_o    = cs_n_q;
  assign hyper_ck_o       = ck_q;
  assign hyper_ck_no_o    = !ck_q;
  assign hyper_reset_no_o = reset_n_q;

  // little-endian data, byte 0 first
  assign hyper_dq_o      = (state_q == ST_CA) ? ca_q[47:40] : wdata_q[byte_idx*8 +: 8];
  assign hyper_dq_oe_o   = (state_q == ST_CA) || (state_q == ST_DATA && we_q);
  // rwds high masks the byte
  assign hyper_rwds_o    = (state_q == ST_DATA) && we_q && !wstrb_q[byte_idx];
  assign hyper_rwds_oe_o = (state_q == ST_DATA) && we_q;

  assign done_o  = (state_q == ST_FINISH);
  assign rdata_o = rdata_q;

  a_dq_oe_cs: assert property (@(posedge clk_i) disable iff (reset_i)
    hyper_dq_oe_o |-> !hyper_cs_no_o);

endmodule

/* hw/hyper_arbiter.sv */
// round-robin arbiter between two host ports
// grant held for a whole PHY transaction
// completion routed back to the granted port only
`timescale 1ns/1ns

module hyper_arbiter (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic [1:0]       req_i,
  input  logic [1:0]       we_i,
  input  hyper_pkg::addr_t addr_i  [1:0],
  input  hyper_pkg::data_t wdata_i [1:0],
  input  hyper_pkg::strb_t wstrb_i [1:0],
  output logic [1:0]       done_o,
  output logic             phy_req_o,
  output logic             phy_we_o,
  output hyper_pkg::addr_t phy_addr_o,
  output hyper_pkg::data_t phy_wdata_o,
  output hyper_pkg::strb_t phy_wstrb_o,
  input  logic             phy_done_i
);

  logic       busy_q;
  logic       last_q;
  logic       other;
  logic [1:0] grant_q;
  logic [1:0] grant_pick;
  logic [1:0] grant;
  logic       sel;

  // the port not served last goes first
  assign other = !last_q;

  always_comb begin
    grant_pick = 2'b00;
    if (req_i[other]) begin
      grant_pick[other] = 1'b1;
    end else if (req_i[last_q]) begin
      grant_pick[last_q] = 1'b1;
    end
  end

  assign grant = busy_q ? grant_q : grant_pick;
  assign sel   = grant[1];

  assign phy_req_o   = |(grant & req_i);
  assign phy_we_o    = we_i[sel];
  assign phy_addr_o  = addr_i[sel];
  assign phy_wdata_o = wdata_i[sel];
  assign phy_wstrb_o = wstrb_i[sel];
  assign done_o      = grant & {2{phy_done_i}};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      last_q  <= 1'b1;
      grant_q <= 2'b00;
    end else if (!busy_q && |grant_pick) begin
      busy_q  <= 1'b1;
      grant_q <= grant_pick;
    end else if (busy_q && phy_done_i) begin
      busy_q  <= 1'b0;
      last_q  <= sel;
      grant_q <= 2'b00;
    end
  end

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(grant));
  a_grant_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    busy_q && !phy_done_i |=> $stable(grant));

endmodule

/* hw/hyper_axil_port.sv */
// AXI4-Lite slave port for single-beat 32-bit accesses
// turns one read or write into a memory request
// range check against the device size, SLVERR without a bus access
`timescale 1ns/1ns

module hyper_axil_port #(
  parameter int MEM_ADDR_WIDTH = 12
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             s_awvalid_i,
  output logic             s_awready_o,
  input  hyper_pkg::addr_t s_awaddr_i,
  input  logic             s_wvalid_i,
  output logic             s_wready_o,
  input  hyper_pkg::data_t s_wdata_i,
  input  hyper_pkg::strb_t s_wstrb_i,
  output logic             s_bvalid_o,
  input  logic             s_bready_i,
  output hyper_pkg::resp_t s_bresp_o,
  input  logic             s_arvalid_i,
  output logic             s_arready_o,
  input  hyper_pkg::addr_t s_araddr_i,
  output logic             s_rvalid_o,
  input  logic             s_rready_i,
  output hyper_pkg::data_t s_rdata_o,
  output hyper_pkg::resp_t s_rresp_o,
  output logic             req_o,
  output logic             we_o,
  output hyper_pkg::addr_t addr_o,
  output hyper_pkg::data_t wdata_o,
  output hyper_pkg::strb_t wstrb_o,
  input  logic             done_i,
  input  hyper_pkg::data_t rdata_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_REQUEST, ST_RESPOND} state_e;

  state_e           state_q;
  logic             rd_hs;
  logic             wr_hs;
  logic             resp_hs;
  logic             in_range;
  hyper_pkg::addr_t acc_addr;
  logic             we_q;
  hyper_pkg::addr_t addr_q;
  hyper_pkg::data_t wdata_q;
  hyper_pkg::strb_t wstrb_q;
  hyper_pkg::data_t rdata_q;
  hyper_pkg::resp_t resp_q;

  // reads win over writes in the same idle cycle
  assign s_arready_o = (state_q == ST_IDLE) && s_arvalid_i;
  assign s_awready_o = (state_q == ST_IDLE) && !s_arvalid_i && s_awvalid_i && s_wvalid_i;
  assign s_wready_o  = s_awready_o;
  assign rd_hs       = s_arready_o;
  assign wr_hs       = s_awready_o;

  assign acc_addr = rd_hs ? s_araddr_i : s_awaddr_i;
  assign in_range = (acc_addr >> MEM_ADDR_WIDTH) == '0;

  assign s_bvalid_o = (state_q == ST_RESPOND) && we_q;
  assign s_rvalid_o = (state_q == ST_RESPOND) && !we_q;
  assign s_bresp_o  = resp_q;
  assign s_rresp_o  = resp_q;
  assign s_rdata_o  = rdata_q;
  assign resp_hs    = (s_bvalid_o && s_bready_i) || (s_rvalid_o && s_rready_i);

  assign req_o   = (state_q == ST_REQUEST);
  assign we_o    = we_q;
  // word aligned towards the memory
  assign addr_o  = {addr_q[31:2], 2'b00};
  assign wdata_o = wdata_q;
  assign wstrb_o = wstrb_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          // out-of-range goes straight to the response
          if (rd_hs || wr_hs) begin
            state_q <= in_range ? ST_REQUEST : ST_RESPOND;
          end
        end
        ST_REQUEST: begin
          if (done_i) begin
            state_q <= ST_RESPOND;
          end
        end
        ST_RESPOND: begin
          if (resp_hs) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_hs || wr_hs) begin
      we_q    <= wr_hs;
      addr_q  <= acc_addr;
      wdata_q <= s_wdata_i;
      wstrb_q <= s_wstrb_i;
      rdata_q <= '0;
      resp_q  <= in_range ? hyper_pkg::RESP_OKAY : hyper_pkg::RESP_SLVERR;
    end
    if (state_q == ST_REQUEST && done_i && !we_q) begin
      rdata_q <= rdata_i;
    end
  end

  // responses held under back-pressure
  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));
  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o));

endmodule

/* hw/hyperbus_pkg.sv */
// HyperBus device-side definitions
// DQ byte type, command/address word layout and transfer sizes
// builder for the 48-bit command/address word

package hyperbus_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [47:0] ca_t;

  // ca bytes go out msb first
  localparam int CA_BYTES   = 6;
  localparam int WORD_BYTES = 4;

  // command bits at the top of the ca word
  localparam int CA_RW_BIT    = 47;
  localparam int CA_AS_BIT    = 46;
  localparam int CA_BURST_BIT = 45;

  // half-word address split into [44:16] upper and [2:0] column
  function automatic ca_t build_ca(input logic read, input logic [31:0] hw_addr);
    ca_t ca;
    ca = '0;
    ca[CA_RW_BIT]    = read;
    ca[CA_AS_BIT]    = 1'b0;
    ca[CA_BURST_BIT] = 1'b1;
    ca[44:16]        = hw_addr[31:3];
    ca[2:0]          = hw_addr[2:0];
    return ca;
  endfunction

endpackage

/* hw/hyper_pkg.sv */
// host-side types for the memory subsystem
// address, data and strobe widths seen by the AXI4-Lite ports
// AXI response codes used by the ports

package hyper_pkg;

  // byte address from the host
  typedef logic [31:0] addr_t;

  // one data word per access
  typedef logic [31:0] data_t;

  // one enable bit per data byte
  typedef logic [3:0] strb_t;

  // AXI response field
  typedef logic [1:0] resp_t;

  // only these two codes are ever returned
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage
